// ==== hw/torch_l2_pkg.sv ====
// L2 timing model shared types
package torch_l2_pkg;

	// Latencies in cycles, counted from the edge that first samples stb
	localparam int MEM_LATENCY   = 4;	// Cacheable read to ack
	localparam int IO_LATENCY    = 2;	// Non-cacheable read to ack
	localparam int WRITE_LATENCY = 2;	// Any write to ack

	// Main memory geometry
	localparam int MEM_WORDS    = 256;	// 64-bit words
	localparam int MEM_ADR_BITS = $clog2(MEM_WORDS);

	// Wishbone classic request from the processor
	typedef struct packed {
		logic        cyc;	// Bus cycle in progress
		logic        stb;	// Strobe
		logic        we;	// 1 for write
		logic [7:0]  sel;	// Byte selects
		logic [31:0] adr;	// Byte address of a 64-bit word
		logic [63:0] dat;	// Write data
		logic        nc;	// Non-cacheable access
	} wb_req_t;

	// Wishbone response
	typedef struct packed {
		logic        ack;	// One cycle per request
		logic [63:0] dat;	// Read data, valid with ack
	} wb_rsp_t;

	// Main memory port request
	typedef struct packed {
		logic                    sel_mm;	// Memory selected this cycle
		logic [MEM_ADR_BITS-1:0] adr;	// Word index
		logic [7:0]              en_read;	// Byte read enables
		logic [7:0]              en_write;	// Byte write enables
		logic [63:0]             dat;	// Write data
	} mem_req_t;

	// Registered read data from memory
	typedef struct packed {
		logic        valid;	// One cycle after a read
		logic [63:0] dat;
	} mem_rsp_t;

	// Tag report toward the processor
	typedef struct packed {
		logic        valid;	// Strobes with each cacheable read ack
		logic [15:0] tag;	// Address bits 31 to 16
	} l2_tag_t;

endpackage

// ==== hw/latency_pipe.sv ====
// Fixed-depth valid/payload delay line
`timescale 1ns/1ps

module latency_pipe #(
	parameter type payload_t = logic,	// Anything packed
	parameter int  DEPTH     = 2	// Stages, at least one
) (
	input  logic     clock,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	logic [DEPTH-1:0] vld;	// One valid bit per stage
	payload_t         data_q [DEPTH];	// Payload stages

	// Valid bits shift every cycle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			vld <= '0;
		end else begin
			vld[0] <= in_valid;
			for (int i = 1; i < DEPTH; i++) begin
				vld[i] <= vld[i-1];
			end
		end
	end

	// Payload only moves along with a valid item
	always_ff @(posedge clock) begin
		if (in_valid) begin
			data_q[0] <= in_data;
		end
		for (int i = 1; i < DEPTH; i++) begin
			if (vld[i-1]) begin
				data_q[i] <= data_q[i-1];
			end
		end
	end

	assign out_valid = vld[DEPTH-1];	// Last stage
	assign out_data  = data_q[DEPTH-1];

	// Nothing can leave the line before it has been filled once
	a_no_valid_after_reset: assert property (
		@(posedge clock) $rose(rst_n) |-> !out_valid [*DEPTH]
	) else $error("latency_pipe: out_valid within DEPTH cycles of reset");

endmodule

// ==== hw/l2_model.sv ====
// Second-level cache timing model
`timescale 1ns/1ps

module l2_model (
	input  logic                   clock,
	input  logic                   rst_n,
	input  torch_l2_pkg::wb_req_t  l2_req,
	output torch_l2_pkg::wb_rsp_t  l2_rsp,
	output torch_l2_pkg::mem_req_t l2_mem_req,
	input  torch_l2_pkg::mem_rsp_t l2_mem_rsp,
	output torch_l2_pkg::l2_tag_t  l2_tag
);
	import torch_l2_pkg::*;

	// Read data travels with its tag through the delay line
	typedef struct packed {
		logic [63:0] dat;
		logic [15:0] tag;
	} rd_ret_t;

	logic                    start;	// New request seen this cycle
	logic                    busy;	// Access in progress
	logic                    ack;
	logic                    mem_sel_q;
	logic [7:0]              mem_rd_en_q;
	logic [7:0]              mem_wr_en_q;
	logic [MEM_ADR_BITS-1:0] mem_adr_q;
	logic [63:0]             mem_dat_q;
	logic [15:0]             tag_q;	// Upper address half of the last request
	logic [WRITE_LATENCY-1:0] wr_sr;	// Write ack timer
	rd_ret_t                 ret_in;
	rd_ret_t                 ret_out;
	logic                    ret_valid;

	// A held stb must not restart the access
	assign start = l2_req.cyc & l2_req.stb & ~busy;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
		end else if (ack) begin
			busy <= 1'b0;	// Master drops stb after this edge
		end
	end

	// Memory access goes out the cycle after the request is taken
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mem_sel_q   <= 1'b0;
			mem_rd_en_q <= '0;
			mem_wr_en_q <= '0;
			wr_sr       <= '0;
		end else begin
			mem_sel_q   <= start;
			mem_rd_en_q <= (start & ~l2_req.we) ? l2_req.sel : 8'h00;	// Read under sel
			mem_wr_en_q <= (start & l2_req.we) ? l2_req.sel : 8'h00;	// Write under sel
			wr_sr       <= {wr_sr[WRITE_LATENCY-2:0], start & l2_req.we};
		end
	end

	// Address, data and tag held for the whole access
	always_ff @(posedge clock) begin
		if (start) begin
			mem_adr_q <= l2_req.adr[MEM_ADR_BITS+2:3];	// Word index
			mem_dat_q <= l2_req.dat;
			tag_q     <= l2_req.adr[31:16];
		end
	end

	assign l2_mem_req = '{
		sel_mm:   mem_sel_q,
		adr:      mem_adr_q,
		en_read:  mem_rd_en_q,
		en_write: mem_wr_en_q,
		dat:      mem_dat_q
	};

	// Returned word waits out the rest of MEM_LATENCY
	assign ret_in = '{dat: l2_mem_rsp.dat, tag: tag_q};

	latency_pipe #(
		.payload_t (rd_ret_t),
		.DEPTH     (MEM_LATENCY - 2)	// Request and memory stages take two
	) rd_pipe_inst (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (l2_mem_rsp.valid),
		.in_data   (ret_in),
		.out_valid (ret_valid),
		.out_data  (ret_out)
	);

	assign ack    = ret_valid | wr_sr[WRITE_LATENCY-1];
	assign l2_rsp = '{ack: ack, dat: ret_out.dat};
	assign l2_tag = '{valid: ret_valid, tag: ret_out.tag};	// Strobe only on reads

	// Every ack belongs to a bus cycle that is still open
	a_ack_inside_cyc: assert property (
		@(posedge clock) disable iff (!rst_n) $rose(ack) |-> l2_req.cyc
	) else $error("l2_model: ack rose while cyc low");

endmodule

// ==== hw/gate_array.sv ====
// Bus decode and memory port gate array
`timescale 1ns/1ps

module gate_array (
	input  logic                   clock,
	input  logic                   rst_n,
	input  torch_l2_pkg::wb_req_t  cpu_req,
	output torch_l2_pkg::wb_rsp_t  cpu_rsp,
	output torch_l2_pkg::wb_req_t  l2_req,
	input  torch_l2_pkg::wb_rsp_t  l2_rsp,
	input  torch_l2_pkg::mem_req_t l2_mem_req,
	output torch_l2_pkg::mem_req_t mem_req,
	input  torch_l2_pkg::mem_rsp_t mem_rsp,
	output torch_l2_pkg::mem_rsp_t l2_mem_rsp
);
	import torch_l2_pkg::*;

	logic                     io_start;	// New non-cacheable request
	logic                     io_busy;
	logic                     io_ack;
	logic                     io_rd_valid;
	logic [63:0]              io_rd_dat;
	logic [WRITE_LATENCY-1:0] io_wr_sr;	// I/O write ack timer
	logic                     rd_from_io;	// Owner of the read in flight
	mem_req_t                 io_mem_req;

	// Cacheable requests pass straight through with stb masked by nc
	always_comb begin
		l2_req     = cpu_req;
		l2_req.stb = cpu_req.stb & ~cpu_req.nc;
	end

	assign io_start = cpu_req.cyc & cpu_req.stb & cpu_req.nc & ~io_busy;

	// Short I/O path hits memory in the same cycle
	always_comb begin
		io_mem_req.sel_mm   = io_start;
		io_mem_req.adr      = cpu_req.adr[MEM_ADR_BITS+2:3];
		io_mem_req.en_read  = (io_start & ~cpu_req.we) ? cpu_req.sel : 8'h00;
		io_mem_req.en_write = (io_start & cpu_req.we) ? cpu_req.sel : 8'h00;
		io_mem_req.dat      = cpu_req.dat;
	end

	assign mem_req = l2_mem_req.sel_mm ? l2_mem_req : io_mem_req;	// L2 owns the port when it asks

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			io_busy    <= 1'b0;
			io_wr_sr   <= '0;
			rd_from_io <= 1'b0;
		end else begin
			if (io_start) begin
				io_busy <= 1'b1;
			end else if (io_ack) begin
				io_busy <= 1'b0;
			end
			io_wr_sr <= {io_wr_sr[WRITE_LATENCY-2:0], io_start & cpu_req.we};
			if (mem_req.sel_mm && |mem_req.en_read) begin
				rd_from_io <= io_start;	// Remember who gets the data back
			end
		end
	end

	// Read data split by owner
	assign l2_mem_rsp = '{valid: mem_rsp.valid & ~rd_from_io, dat: mem_rsp.dat};

	latency_pipe #(
		.payload_t (logic [63:0]),
		.DEPTH     (IO_LATENCY - 1)	// Memory stage takes one
	) io_pipe_inst (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (mem_rsp.valid & rd_from_io),
		.in_data   (mem_rsp.dat),
		.out_valid (io_rd_valid),
		.out_data  (io_rd_dat)
	);

	assign io_ack = io_rd_valid | io_wr_sr[WRITE_LATENCY-1];

	// Only one side can answer for a given transaction
	assign cpu_rsp = '{ack: io_ack | l2_rsp.ack, dat: io_rd_valid ? io_rd_dat : l2_rsp.dat};

	// One outstanding transaction keeps the two requesters apart
	a_one_mem_owner: assert property (
		@(posedge clock) disable iff (!rst_n) !(l2_mem_req.sel_mm && io_mem_req.sel_mm)
	) else $error("gate_array: L2 and I/O both request memory");

endmodule

// ==== hw/main_memory.sv ====
// Byte-enabled main memory
`timescale 1ns/1ps

module main_memory (
	input  logic                   clock,
	input  torch_l2_pkg::mem_req_t mem_req,
	output torch_l2_pkg::mem_rsp_t mem_rsp
);
	import torch_l2_pkg::*;

	logic [63:0] mem [MEM_WORDS];	// Word array, contents survive reset
	logic        rd_valid;
	logic [63:0] rd_dat;

	// Byte lanes written under en_write
	always_ff @(posedge clock) begin
		if (mem_req.sel_mm) begin
			for (int b = 0; b < 8; b++) begin
				if (mem_req.en_write[b]) begin
					mem[mem_req.adr][b*8 +: 8] <= mem_req.dat[b*8 +: 8];
				end
			end
		end
	end

	// Registered read, unread lanes return zero
	always_ff @(posedge clock) begin
		rd_valid <= mem_req.sel_mm & |mem_req.en_read;
		for (int b = 0; b < 8; b++) begin
			if (mem_req.sel_mm && mem_req.en_read[b]) begin
				rd_dat[b*8 +: 8] <= mem[mem_req.adr][b*8 +: 8];
			end else begin
				rd_dat[b*8 +: 8] <= 8'h00;
			end
		end
	end

	assign mem_rsp = '{valid: rd_valid, dat: rd_dat};	// Valid one cycle after the read

endmodule

// ==== hw/torch_l2_top.sv ====
// L2 timing model board top
`timescale 1ns/1ps

module torch_l2_top (
	input  logic                  clock,
	input  logic                  rst_n,
	input  torch_l2_pkg::wb_req_t cpu_req,	// Processor bus
	output torch_l2_pkg::wb_rsp_t cpu_rsp,
	output torch_l2_pkg::l2_tag_t l2_tag	// Tag report to processor
);
	import torch_l2_pkg::*;

	wb_req_t  l2_req;	// Cacheable requests
	wb_rsp_t  l2_rsp;
	mem_req_t l2_mem_req;	// L2 side of the memory port
	mem_req_t mem_req;	// Steered memory port
	mem_rsp_t mem_rsp;
	mem_rsp_t l2_mem_rsp;

	gate_array gate_array_inst (
		.clock      (clock),
		.rst_n      (rst_n),
		.cpu_req    (cpu_req),
		.cpu_rsp    (cpu_rsp),
		.l2_req     (l2_req),
		.l2_rsp     (l2_rsp),
		.l2_mem_req (l2_mem_req),
		.mem_req    (mem_req),
		.mem_rsp    (mem_rsp),
		.l2_mem_rsp (l2_mem_rsp)
	);

	l2_model l2_model_inst (
		.clock      (clock),
		.rst_n      (rst_n),
		.l2_req     (l2_req),
		.l2_rsp     (l2_rsp),
		.l2_mem_req (l2_mem_req),
		.l2_mem_rsp (l2_mem_rsp),
		.l2_tag     (l2_tag)
	);

	main_memory main_memory_inst (
		.clock   (clock),
		.mem_req (mem_req),
		.mem_rsp (mem_rsp)
	);

endmodule

// ==== test/torch_l2_tb.sv ====
// L2 timing model testbench
`timescale 1ns/1ps

module torch_l2_tb;
	import torch_l2_pkg::*;

	localparam int NUM_TESTS   = 12;
	localparam int ACK_TIMEOUT = 50;	// Cycles per transaction

	// One row of the stimulus table
	typedef struct packed {
		logic        we;
		logic        nc;
		logic [31:0] adr;
		logic [7:0]  sel;
		logic [63:0] dat;
		logic [63:0] exp_dat;	// Shadow word, reads only
		logic [7:0]  exp_lat;	// Cycles from E0 to ack
		logic [1:0]  gap;	// Extra idle cycles after ack
	} entry_t;

	logic    clock;
	logic    rst_n;
	wb_req_t cpu_req;
	wb_rsp_t cpu_rsp;
	l2_tag_t l2_tag;

	entry_t      stim [NUM_TESTS];
	string       test_name [NUM_TESTS];
	logic [63:0] shadow [MEM_WORDS];	// Expected memory contents
	int          n_entries;

	torch_l2_top torch_l2_top_inst (
		.clock   (clock),
		.rst_n   (rst_n),
		.cpu_req (cpu_req),
		.cpu_rsp (cpu_rsp),
		.l2_tag  (l2_tag)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;	// 20 ns period
	end

	task automatic check_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		if (exp !== act) begin
			$display("ERROR %s expected %h actual %h", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// Byte address to memory word index
	function automatic logic [MEM_ADR_BITS-1:0] word_index(input logic [31:0] adr);
		return adr[MEM_ADR_BITS+2:3];
	endfunction

	// Appends a row, shadow memory gives the expected read word
	task automatic add_entry(input string name, input logic we, input logic nc,
			input logic [31:0] adr, input logic [7:0] sel);
		entry_t                  e;
		logic [MEM_ADR_BITS-1:0] idx;
		idx   = word_index(adr);
		e.we  = we;
		e.nc  = nc;
		e.adr = adr;
		e.sel = sel;
		e.dat = {$urandom, $urandom};
		e.gap = 2'($urandom_range(3, 0));
		if (we) begin
			for (int b = 0; b < 8; b++) begin
				if (sel[b]) shadow[idx][b*8 +: 8] = e.dat[b*8 +: 8];	// Merge under sel
			end
			e.exp_dat = '0;
			e.exp_lat = 8'(WRITE_LATENCY);
		end else begin
			e.exp_dat = shadow[idx];
			e.exp_lat = nc ? 8'(IO_LATENCY) : 8'(MEM_LATENCY);
		end
		stim[n_entries]      = e;
		test_name[n_entries] = name;
		n_entries++;
	endtask

	// Drives one request, waits for ack, checks it, then idles
	task automatic run_entry(input int i);
		entry_t e;
		int     lat;
		logic   got;
		logic   tag_exp;
		e       = stim[i];
		tag_exp = ~e.we & ~e.nc;	// Only cacheable reads report a tag
		cpu_req = '{cyc: 1'b1, stb: 1'b1, we: e.we, sel: e.sel, adr: e.adr,
			dat: e.dat, nc: e.nc};
		@(posedge clock);	// E0
		lat = 0;
		got = 1'b0;
		while (!got && lat < ACK_TIMEOUT) begin
			@(negedge clock);
			lat++;
			got = (cpu_rsp.ack === 1'b1);
			check_value({test_name[i], " tag valid"}, 64'(got & tag_exp), 64'(l2_tag.valid));
		end
		if (!got) begin
			$display("No acknowledge arrived for %s within %0d cycles", test_name[i],
				ACK_TIMEOUT);
			$display("TEST RESULT: FAIL");
			$fatal(1, "ack timeout");
		end
		check_value({test_name[i], " latency"}, 64'(e.exp_lat), 64'(lat));
		if (!e.we) check_value({test_name[i], " read data"}, e.exp_dat, cpu_rsp.dat);
		if (tag_exp) check_value({test_name[i], " tag"}, 64'(e.adr[31:16]), 64'(l2_tag.tag));
		@(posedge clock);	// Master samples ack
		@(negedge clock);
		check_value({test_name[i], " single ack"}, 64'(0), 64'(cpu_rsp.ack));
		cpu_req.cyc = 1'b0;
		cpu_req.stb = 1'b0;
		repeat (e.gap + 1) begin	// One idle cycle plus the random gap
			@(negedge clock);
			check_value({test_name[i], " idle ack"}, 64'(0), 64'(cpu_rsp.ack));
			check_value({test_name[i], " idle tag"}, 64'(0), 64'(l2_tag.valid));
		end
	endtask

	initial begin
		int unsigned seed;
		seed      = $urandom(32'h7928_bd6c);	// Seed once
		cpu_req   = '0;
		rst_n     = 1'b0;
		n_entries = 0;

		// Full words first so that no read sees an unwritten byte
		add_entry("c_wr_a",    1'b1, 1'b0, 32'h1234_0040, 8'hff);
		add_entry("c_rd_a",    1'b0, 1'b0, 32'h1234_0040, 8'hff);
		add_entry("nc_wr_b",   1'b1, 1'b1, 32'h0a0b_0100, 8'hff);
		add_entry("nc_rd_b",   1'b0, 1'b1, 32'h0a0b_0100, 8'hff);
		add_entry("c_rd_b",    1'b0, 1'b0, 32'h0a0b_0100, 8'hff);	// Shared memory
		add_entry("c_wr_c",    1'b1, 1'b0, 32'hbeef_07f8, 8'hff);
		add_entry("c_part_c",  1'b1, 1'b0, 32'hbeef_07f8, 8'ha5);
		add_entry("nc_part_c", 1'b1, 1'b1, 32'hbeef_07f8, 8'h18);
		add_entry("c_rd_c",    1'b0, 1'b0, 32'hbeef_07f8, 8'hff);
		add_entry("nc_rd_c",   1'b0, 1'b1, 32'hbeef_07f8, 8'hff);
		add_entry("nc_part_a", 1'b1, 1'b1, 32'h1234_0040, 8'hf0);
		add_entry("c_rd_a2",   1'b0, 1'b0, 32'h1234_0040, 8'hff);

		repeat (16) begin	// Reset held for 16 cycles
			@(negedge clock);
			check_value("reset ack", 64'(0), 64'(cpu_rsp.ack));
			check_value("reset tag valid", 64'(0), 64'(l2_tag.valid));
		end
		rst_n = 1'b1;
		@(negedge clock);
		check_value("post reset ack", 64'(0), 64'(cpu_rsp.ack));
		check_value("post reset tag valid", 64'(0), 64'(l2_tag.valid));

		for (int i = 0; i < n_entries; i++) begin
			run_entry(i);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== torch_l2.f ====
hw/torch_l2_pkg.sv
hw/latency_pipe.sv
hw/l2_model.sv
hw/gate_array.sv
hw/main_memory.sv
hw/torch_l2_top.sv
test/torch_l2_tb.sv
